// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	localparam int XLEN       = 32;
	localparam int REG_W      = 5;
	localparam int TIMER_W    = 16;
	localparam int PC_SRC_W   = 3;
	localparam int EXC_CODE_W = 5;

	// Boot and handler addresses
	localparam logic [XLEN-1:0] RESET_PC   = 32'hbfc0_0000;
	localparam logic [XLEN-1:0] EXC_VECTOR = 32'h8000_0180;

	// Next-PC sources
	localparam logic [PC_SRC_W-1:0] PC_SEQ    = 3'd0;
	localparam logic [PC_SRC_W-1:0] PC_JUMP   = 3'd1;
	localparam logic [PC_SRC_W-1:0] PC_JR     = 3'd2;
	localparam logic [PC_SRC_W-1:0] PC_BRANCH = 3'd3;
	localparam logic [PC_SRC_W-1:0] PC_VECTOR = 3'd4;
	localparam logic [PC_SRC_W-1:0] PC_ERET   = 3'd5;

	// Cause register codes, as in the MIPS ExcCode field
	localparam logic [EXC_CODE_W-1:0] EXC_INT = 5'd0;
	localparam logic [EXC_CODE_W-1:0] EXC_SYS = 5'd8;

	// Opcodes whose rt field is a source register
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// Exception level states
	localparam logic ST_RUN    = 1'b0;
	localparam logic ST_KERNEL = 1'b1;

	typedef struct packed {
		logic [5:0]       opcode;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [REG_W-1:0] rd;
		logic [4:0]       shamt;
		logic [5:0]       funct;
	} r_instr_t;

	typedef struct packed {
		logic [5:0]       opcode;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [15:0]      imm;
	} i_instr_t;

	typedef union packed {
		r_instr_t r;
		i_instr_t i;
	} instr_u;

endpackage

`default_nettype wire

// ==== hw/exc_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exc_if import pipe_pkg::*; ();

	// Strobes from the hazard unit, never high together
	logic                  take;
	logic                  eret;
	logic [EXC_CODE_W-1:0] code;
	logic [XLEN-1:0]       epc_next;

	// State held by the exception FSM
	logic                  exl;
	logic [XLEN-1:0]       epc;

	modport ctrl (
		output take,
		output eret,
		output code,
		output epc_next,
		input  exl
	);

	modport state (
		input  take,
		input  eret,
		input  code,
		input  epc_next,
		output exl,
		output epc
	);

endinterface

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import pipe_pkg::*; (
	input  instr_u                ifid_instr,
	input  logic [REG_W-1:0]      idex_rd,
	input  logic                  idex_mem_read,
	input  logic                  id_jump,
	input  logic                  id_jr,
	input  logic [XLEN-1:0]       predicted_idex_pc,
	input  logic [XLEN-1:0]       target_exmem_pc,
	input  logic                  exmem_syscall,
	input  logic                  exmem_eret,
	input  logic                  ext_intr,
	input  logic                  timer_irq,
	input  logic                  mem_stall,
	output logic [PC_SRC_W-1:0]   pc_src,
	output logic                  pc_stall,
	output logic                  ifid_stall,
	output logic                  idex_stall,
	output logic                  exmem_stall,
	output logic                  ifid_flush,
	output logic                  idex_flush,
	output logic                  exmem_flush,
	output logic                  bpu_write_en,
	exc_if.ctrl                   exc
);

	//////////////////////////////////////////////////
	// Event detection
	//////////////////////////////////////////////////

	logic             reads_rt;
	logic             load_use;
	logic             mispredict;
	logic             irq;
	logic             exc_req;
	logic             eret_req;
	logic             redirect;

	// Opcodes that use rt as a source register
	assign reads_rt = (ifid_instr.r.opcode == OP_RTYPE) || (ifid_instr.r.opcode == OP_SW) ||
		(ifid_instr.r.opcode == OP_BEQ) || (ifid_instr.r.opcode == OP_BNE);

	// rt sits in the same field in both formats
	assign load_use = idex_mem_read && (idex_rd != '0) &&
		((idex_rd == ifid_instr.r.rs) || (reads_rt && (idex_rd == ifid_instr.i.rt)));

	assign mispredict = (predicted_idex_pc != target_exmem_pc);
	assign irq        = ext_intr | timer_irq;

	// Exceptions only at user level, eret only in the handler
	assign exc_req  = ~exc.exl & (irq | exmem_syscall);
	assign eret_req = exc.exl & exmem_eret;

	// Anything that changes the fetch path beats a load-use stall
	assign redirect = id_jump | id_jr | mispredict | exc_req | eret_req;

	//////////////////////////////////////////////////
	// Priority resolution, lowest first
	//////////////////////////////////////////////////

	always_comb
	begin
		pc_src       = PC_SEQ;
		pc_stall     = 1'b0;
		ifid_stall   = 1'b0;
		idex_stall   = 1'b0;
		exmem_stall  = 1'b0;
		ifid_flush   = 1'b0;
		idex_flush   = 1'b0;
		exmem_flush  = 1'b0;
		bpu_write_en = 1'b0;
		exc.take     = 1'b0;
		exc.eret     = 1'b0;
		exc.code     = EXC_INT;
		exc.epc_next = '0;

		// Hold fetch and decode, bubble into EX
		if (load_use && !redirect)
		begin
			pc_stall   = 1'b1;
			ifid_stall = 1'b1;
			idex_flush = 1'b1;
		end

		if (id_jump)
		begin
			pc_src     = PC_JUMP;
			ifid_flush = 1'b1;
		end

		if (id_jr)
		begin
			pc_src     = PC_JR;
			ifid_flush = 1'b1;
		end

		// Wrong path already in IF, ID and EX
		if (mispredict)
		begin
			pc_src       = PC_BRANCH;
			ifid_flush   = 1'b1;
			idex_flush   = 1'b1;
			exmem_flush  = 1'b1;
			bpu_write_en = 1'b1;
		end

		if (exc_req)
		begin
			pc_src       = PC_VECTOR;
			ifid_flush   = 1'b1;
			idex_flush   = 1'b1;
			exmem_flush  = 1'b1;
			bpu_write_en = 1'b0;
			exc.take     = 1'b1;
			exc.code     = irq ? EXC_INT : EXC_SYS;
			// Interrupt resumes at the correct path, not the predicted one
			if (!irq || mispredict)
				exc.epc_next = target_exmem_pc;
			else
				exc.epc_next = predicted_idex_pc;
		end

		if (eret_req)
		begin
			pc_src       = PC_ERET;
			ifid_flush   = 1'b1;
			idex_flush   = 1'b1;
			exmem_flush  = 1'b1;
			bpu_write_en = 1'b0;
			exc.eret     = 1'b1;
		end

		// Memory back-pressure freezes everything
		if (mem_stall)
		begin
			pc_src       = PC_SEQ;
			pc_stall     = 1'b1;
			ifid_stall   = 1'b1;
			idex_stall   = 1'b1;
			exmem_stall  = 1'b1;
			ifid_flush   = 1'b0;
			idex_flush   = 1'b0;
			exmem_flush  = 1'b0;
			bpu_write_en = 1'b0;
			exc.take     = 1'b0;
			exc.eret     = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/exc_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_fsm import pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic [EXC_CODE_W-1:0] cause,
	exc_if.state                  exc
);

	logic            state;
	logic [XLEN-1:0] epc_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_RUN;
			epc_q <= '0;
			cause <= '0;
		end
		else
		begin
			case (state)
				ST_RUN:
				begin
					// Record where to resume and why
					if (exc.take)
					begin
						state <= ST_KERNEL;
						epc_q <= exc.epc_next;
						cause <= exc.code;
					end
				end
				ST_KERNEL:
				begin
					// EPC and cause stay readable after return
					if (exc.eret)
						state <= ST_RUN;
				end
				default:
				begin
					state <= ST_RUN;
				end
			endcase
		end
	end

	assign exc.exl = (state == ST_KERNEL);
	assign exc.epc = epc_q;

endmodule

`default_nettype wire

// ==== hw/cp0_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_timer import pipe_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cmp_we,
	input  logic [TIMER_W-1:0] cmp_wdata,
	output logic               timer_irq
);

	logic [TIMER_W-1:0] count;
	logic [TIMER_W-1:0] compare;

	// Count runs every cycle, wraps freely
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			compare <= '0;
		else if (cmp_we)
			compare <= cmp_wdata;
	end

	// Pending until software rewrites compare
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			timer_irq <= 1'b0;
		else if (cmp_we)
			timer_irq <= 1'b0;
		else if (count == compare)
			timer_irq <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit import pipe_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [PC_SRC_W-1:0] pc_src,
	input  logic                pc_stall,
	input  logic [XLEN-1:0]     jump_target,
	input  logic [XLEN-1:0]     jr_target,
	input  logic [XLEN-1:0]     target_exmem_pc,
	input  logic [XLEN-1:0]     epc,
	output logic [XLEN-1:0]     pc
);

	logic [XLEN-1:0] pc_next;

	// Next-PC mux
	always_comb
	begin
		case (pc_src)
			PC_JUMP:   pc_next = jump_target;
			PC_JR:     pc_next = jr_target;
			PC_BRANCH: pc_next = target_exmem_pc;
			PC_VECTOR: pc_next = EXC_VECTOR;
			PC_ERET:   pc_next = epc;
			default:   pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (!pc_stall)
			pc <= pc_next;
	end

endmodule

`default_nettype wire

// ==== hw/pipe_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top import pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           ifid_instr,
	input  logic [REG_W-1:0]      idex_rd,
	input  logic                  idex_mem_read,
	input  logic                  id_jump,
	input  logic                  id_jr,
	input  logic [XLEN-1:0]       jump_target,
	input  logic [XLEN-1:0]       jr_target,
	input  logic [XLEN-1:0]       predicted_idex_pc,
	input  logic [XLEN-1:0]       target_exmem_pc,
	input  logic                  exmem_syscall,
	input  logic                  exmem_eret,
	input  logic                  ext_intr,
	input  logic                  mem_stall,
	input  logic                  cmp_we,
	input  logic [TIMER_W-1:0]    cmp_wdata,
	output logic [XLEN-1:0]       pc,
	output logic                  pc_stall,
	output logic                  ifid_stall,
	output logic                  idex_stall,
	output logic                  exmem_stall,
	output logic                  ifid_flush,
	output logic                  idex_flush,
	output logic                  exmem_flush,
	output logic                  bpu_write_en,
	output logic                  exl,
	output logic [XLEN-1:0]       epc,
	output logic [EXC_CODE_W-1:0] cause,
	output logic                  timer_irq
);

	logic [PC_SRC_W-1:0] pc_src;

	exc_if exc_bus ();

	hazard_unit u_hazard_unit (
		.ifid_instr        (ifid_instr),
		.idex_rd           (idex_rd),
		.idex_mem_read     (idex_mem_read),
		.id_jump           (id_jump),
		.id_jr             (id_jr),
		.predicted_idex_pc (predicted_idex_pc),
		.target_exmem_pc   (target_exmem_pc),
		.exmem_syscall     (exmem_syscall),
		.exmem_eret        (exmem_eret),
		.ext_intr          (ext_intr),
		.timer_irq         (timer_irq),
		.mem_stall         (mem_stall),
		.pc_src            (pc_src),
		.pc_stall          (pc_stall),
		.ifid_stall        (ifid_stall),
		.idex_stall        (idex_stall),
		.exmem_stall       (exmem_stall),
		.ifid_flush        (ifid_flush),
		.idex_flush        (idex_flush),
		.exmem_flush       (exmem_flush),
		.bpu_write_en      (bpu_write_en),
		.exc               (exc_bus.ctrl)
	);

	exc_fsm u_exc_fsm (
		.clk   (clk),
		.rst_n (rst_n),
		.cause (cause),
		.exc   (exc_bus.state)
	);

	cp0_timer u_cp0_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmp_we    (cmp_we),
		.cmp_wdata (cmp_wdata),
		.timer_irq (timer_irq)
	);

	pc_unit u_pc_unit (
		.clk             (clk),
		.rst_n           (rst_n),
		.pc_src          (pc_src),
		.pc_stall        (pc_stall),
		.jump_target     (jump_target),
		.jr_target       (jr_target),
		.target_exmem_pc (target_exmem_pc),
		.epc             (exc_bus.epc),
		.pc              (pc)
	);

	// Exception state out to the core
	assign exl = exc_bus.exl;
	assign epc = exc_bus.epc;

endmodule

`default_nettype wire

// ==== dv/tb_pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl import pipe_pkg::*; ();

	localparam int NUM_CYCLES = 4000;
	localparam int TIMER_WAIT = 64;

	logic                  clk;
	logic                  rst_n;
	logic [31:0]           ifid_instr;
	logic [REG_W-1:0]      idex_rd;
	logic                  idex_mem_read;
	logic                  id_jump;
	logic                  id_jr;
	logic [XLEN-1:0]       jump_target;
	logic [XLEN-1:0]       jr_target;
	logic [XLEN-1:0]       predicted_idex_pc;
	logic [XLEN-1:0]       target_exmem_pc;
	logic                  exmem_syscall;
	logic                  exmem_eret;
	logic                  ext_intr;
	logic                  mem_stall;
	logic                  cmp_we;
	logic [TIMER_W-1:0]    cmp_wdata;
	logic [XLEN-1:0]       pc;
	logic                  pc_stall;
	logic                  ifid_stall;
	logic                  idex_stall;
	logic                  exmem_stall;
	logic                  ifid_flush;
	logic                  idex_flush;
	logic                  exmem_flush;
	logic                  bpu_write_en;
	logic                  exl;
	logic [XLEN-1:0]       epc;
	logic [EXC_CODE_W-1:0] cause;
	logic                  timer_irq;

	// Reference model state, as seen after the coming clock edge
	logic [XLEN-1:0]       m_pc;
	logic                  m_exl;
	logic [XLEN-1:0]       m_epc;
	logic [EXC_CODE_W-1:0] m_cause;
	logic [TIMER_W-1:0]    m_count;
	logic [TIMER_W-1:0]    m_compare;
	logic                  m_irq;

	// Predicted combinational results for the current cycle
	logic [3:0]            e_stall;
	logic [2:0]            e_flush;
	logic                  e_bpu;
	logic [XLEN-1:0]       e_next_pc;
	logic                  e_take;
	logic                  e_eret;
	logic [EXC_CODE_W-1:0] e_code;
	logic [XLEN-1:0]       e_epc_next;

	int waited;

	pipe_ctrl_top u_pipe_ctrl_top (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic drive_idle();
		ifid_instr        <= '0;
		idex_rd           <= '0;
		idex_mem_read     <= 1'b0;
		id_jump           <= 1'b0;
		id_jr             <= 1'b0;
		jump_target       <= '0;
		jr_target         <= '0;
		predicted_idex_pc <= '0;
		target_exmem_pc   <= '0;
		exmem_syscall     <= 1'b0;
		exmem_eret        <= 1'b0;
		ext_intr          <= 1'b0;
		mem_stall         <= 1'b0;
		cmp_we            <= 1'b0;
		cmp_wdata         <= '0;
	endtask

	task automatic drive_random();
		logic [5:0]  op;
		logic [31:0] word;
		int          pick;
		pick = int'($urandom_range(0, 5));
		case (pick)
			0:       op = OP_RTYPE;
			1:       op = OP_SW;
			2:       op = OP_BEQ;
			3:       op = OP_BNE;
			4:       op = 6'h23;
			default: op = 6'h08;
		endcase
		// Small register set so that hazards actually happen
		ifid_instr    <= {op, 5'($urandom_range(0, 3)), 5'($urandom_range(0, 3)), 16'($urandom)};
		idex_rd       <= 5'($urandom_range(0, 3));
		idex_mem_read <= ($urandom_range(0, 1) == 1);
		id_jump       <= ($urandom_range(0, 7) == 0);
		id_jr         <= ($urandom_range(0, 7) == 0);
		word = $urandom;
		jump_target <= {word[31:2], 2'b00};
		word = $urandom;
		jr_target <= {word[31:2], 2'b00};
		word = $urandom;
		predicted_idex_pc <= {word[31:2], 2'b00};
		if ($urandom_range(0, 9) == 0)
			target_exmem_pc <= {word[31:2], 2'b00} ^ 32'h40;
		else
			target_exmem_pc <= {word[31:2], 2'b00};
		exmem_syscall <= ($urandom_range(0, 19) == 0);
		exmem_eret    <= ($urandom_range(0, 5) == 0);
		ext_intr      <= ($urandom_range(0, 24) == 0);
		mem_stall     <= ($urandom_range(0, 7) == 0);
		cmp_we        <= ($urandom_range(0, 29) == 0);
		cmp_wdata     <= m_count + 16'($urandom_range(2, 20));
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	task automatic predict_controls();
		logic [5:0]       op;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic             rt_is_src;
		logic             load_use;
		logic             mispred;
		logic             intr;
		op        = ifid_instr[31:26];
		rs        = ifid_instr[25:21];
		rt        = ifid_instr[20:16];
		rt_is_src = (op == OP_RTYPE) || (op == OP_SW) || (op == OP_BEQ) || (op == OP_BNE);
		load_use  = idex_mem_read && (idex_rd != '0) &&
			((idex_rd == rs) || (rt_is_src && (idex_rd == rt)));
		mispred   = (predicted_idex_pc != target_exmem_pc);
		intr      = ext_intr || m_irq;

		e_stall    = 4'b0000;
		e_flush    = 3'b000;
		e_bpu      = 1'b0;
		e_next_pc  = m_pc + 32'd4;
		e_take     = 1'b0;
		e_eret     = 1'b0;
		e_code     = EXC_INT;
		e_epc_next = '0;

		// Highest priority first
		if (mem_stall)
		begin
			e_stall   = 4'b1111;
			e_next_pc = m_pc;
		end
		else if (exmem_eret && m_exl)
		begin
			e_flush   = 3'b111;
			e_next_pc = m_epc;
			e_eret    = 1'b1;
		end
		else if (!m_exl && (intr || exmem_syscall))
		begin
			e_flush    = 3'b111;
			e_next_pc  = EXC_VECTOR;
			e_take     = 1'b1;
			e_code     = intr ? EXC_INT : EXC_SYS;
			e_epc_next = (intr && !mispred) ? predicted_idex_pc : target_exmem_pc;
		end
		else if (mispred)
		begin
			e_flush   = 3'b111;
			e_next_pc = target_exmem_pc;
			e_bpu     = 1'b1;
		end
		else if (id_jr)
		begin
			e_flush   = 3'b100;
			e_next_pc = jr_target;
		end
		else if (id_jump)
		begin
			e_flush   = 3'b100;
			e_next_pc = jump_target;
		end
		else if (load_use)
		begin
			e_stall   = 4'b1100;
			e_flush   = 3'b010;
			e_next_pc = m_pc;
		end
	endtask

	task automatic advance_model();
		m_pc = e_next_pc;
		if (e_take)
		begin
			m_exl   = 1'b1;
			m_epc   = e_epc_next;
			m_cause = e_code;
		end
		else if (e_eret)
			m_exl = 1'b0;
		// Old count and compare decide the interrupt
		if (cmp_we)
			m_irq = 1'b0;
		else if (m_count == m_compare)
			m_irq = 1'b1;
		if (cmp_we)
			m_compare = cmp_wdata;
		m_count = m_count + 16'd1;
	endtask

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		$display("Checks failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic check_outputs();
		assert (pc === m_pc) else report_mismatch("pc", pc, m_pc);
		assert (exl === m_exl) else report_mismatch("exl", 32'(exl), 32'(m_exl));
		assert (epc === m_epc) else report_mismatch("epc", epc, m_epc);
		assert (cause === m_cause) else report_mismatch("cause", 32'(cause), 32'(m_cause));
		assert (timer_irq === m_irq)
			else report_mismatch("timer_irq", 32'(timer_irq), 32'(m_irq));
		assert ({pc_stall, ifid_stall, idex_stall, exmem_stall} === e_stall)
			else report_mismatch("stalls", 32'({pc_stall, ifid_stall, idex_stall, exmem_stall}),
				32'(e_stall));
		assert ({ifid_flush, idex_flush, exmem_flush} === e_flush)
			else report_mismatch("flushes", 32'({ifid_flush, idex_flush, exmem_flush}),
				32'(e_flush));
		assert (bpu_write_en === e_bpu)
			else report_mismatch("bpu_write_en", 32'(bpu_write_en), 32'(e_bpu));
	endtask

	// Inputs settle on the rising edge, outputs are sampled mid-cycle
	task automatic run_cycle(input bit use_random);
		@(posedge clk);
		if (use_random)
			drive_random();
		else
			drive_idle();
		@(negedge clk);
		predict_controls();
		check_outputs();
		advance_model();
	endtask

	task automatic write_compare(input logic [TIMER_W-1:0] offset);
		@(posedge clk);
		drive_idle();
		cmp_we    <= 1'b1;
		cmp_wdata <= m_count + offset;
		@(negedge clk);
		predict_controls();
		check_outputs();
		advance_model();
	endtask

	initial
	begin
		void'($urandom(33));
		rst_n <= 1'b0;
		drive_idle();
		m_pc      = RESET_PC;
		m_exl     = 1'b0;
		m_epc     = '0;
		m_cause   = '0;
		m_count   = '0;
		m_compare = '0;
		m_irq     = 1'b0;

		// Reset values while still in reset
		repeat (3) @(posedge clk);
		@(negedge clk);
		predict_controls();
		check_outputs();
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		predict_controls();
		check_outputs();
		advance_model();

		for (int i = 0; i < NUM_CYCLES; i++)
			run_cycle(1'b1);

		// Directed timer sequence, the write clears any pending interrupt first
		write_compare(16'd12);
		run_cycle(1'b0);
		waited = 0;
		while (!timer_irq && waited < TIMER_WAIT)
		begin
			run_cycle(1'b0);
			waited++;
		end
		if (!timer_irq)
		begin
			$display("Timeout: timer interrupt did not rise within %0d cycles", TIMER_WAIT);
			$display("Checks failed");
			$fatal(1, "timer wait timed out");
		end
		repeat (6) run_cycle(1'b0);
		write_compare(16'd30);
		repeat (4) run_cycle(1'b0);
		for (int i = 0; i < 500; i++)
			run_cycle(1'b1);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/pipe_pkg.sv
hw/exc_if.sv
hw/hazard_unit.sv
hw/exc_fsm.sv
hw/cp0_timer.sv
hw/pc_unit.sv
hw/pipe_ctrl_top.sv
dv/tb_pipe_ctrl.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pipe_ctrl
FILELIST = verilog.f
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
